/* verilog/i2c_pkg.sv */
package i2c_pkg;

    // commands accepted by the byte engine
    typedef enum logic [2:0] {
        cmd_idle           = 3'd0,
        cmd_start          = 3'd1,
        cmd_restart        = 3'd2,
        cmd_write_byte     = 3'd3,
        cmd_read_byte_ack  = 3'd4,
        cmd_read_byte_nack = 3'd5,
        cmd_stop           = 3'd6
    } i2c_cmd_t;

    // quarter periods of one scl period, scl high in the upper two
    typedef enum logic [1:0] {
        phase_low_a  = 2'd0,
        phase_low_b  = 2'd1,
        phase_high_a = 2'd2,
        phase_high_b = 2'd3
    } bit_phase_t;

endpackage

/* verilog/eeprom_pkg.sv */
package eeprom_pkg;

    localparam int ADDR_W = 11;   // 2 kbyte array
    localparam int DATA_W = 8;

    typedef logic [ADDR_W-1:0] eeprom_addr_t;
    typedef logic [DATA_W-1:0] eeprom_data_t;

    // page bits sit above the 8-bit word address
    localparam int PAGE_W = ADDR_W - 8;

    // control byte is device type, page, r/w flag
    localparam logic [3:0] DEVICE_TYPE = 4'b1010;
    localparam logic       CTRL_WRITE  = 1'b0;
    localparam logic       CTRL_READ   = 1'b1;

    function automatic eeprom_data_t ctrl_byte(
        input logic [PAGE_W-1:0] page,
        input logic              rnw
    );
        return {DEVICE_TYPE, page, rnw};
    endfunction

endpackage

/* verilog/i2c_byte_engine.sv */
`timescale 1ns/100ps

module i2c_byte_engine #(
    parameter int CLKS_PER_QUARTER = 2
) (
    input  logic              CLK,
    input  logic              RESET,
    input  i2c_pkg::i2c_cmd_t cmd,
    input  logic [7:0]        tx_byte,
    input  logic              cmd_valid,
    output logic              ready,
    output logic              cmd_done,
    output logic [7:0]        rx_byte,
    output logic              ack_ok,
    output logic              scl,
    output logic              sda_oe,
    input  logic              sda_in
);
    import i2c_pkg::*;

    localparam int cnt_w = (CLKS_PER_QUARTER > 1) ? $clog2(CLKS_PER_QUARTER) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(CLKS_PER_QUARTER - 1);

    i2c_cmd_t         cmd_q;        // cmd_idle while nothing runs
    bit_phase_t       phase;
    logic [cnt_w-1:0] qcnt;
    logic [3:0]       bit_cnt;      // 0..7 data, 8 ack
    logic [7:0]       tx_sh;
    logic [7:0]       rx_sh;
    logic             is_read;
    logic             is_byte;
    logic             in_high;
    logic             quarter_end;
    logic             bit_end;
    logic             cmd_end;
    logic             drive_bit;
    logic             scl_nxt;
    logic             sda_nxt;

    assign ready       = (cmd_q == cmd_idle);
    assign is_read     = (cmd_q == cmd_read_byte_ack) || (cmd_q == cmd_read_byte_nack);
    assign is_byte     = is_read || (cmd_q == cmd_write_byte);
    assign in_high     = (phase == phase_high_a) || (phase == phase_high_b);
    assign quarter_end = (qcnt == cnt_last);
    assign bit_end     = quarter_end && (phase == phase_high_b);
    assign cmd_end     = bit_end && (!is_byte || bit_cnt == 4'd8);
    assign rx_byte     = rx_sh;

    // level to pull for the current byte bit
    always_comb
    begin
        if (bit_cnt < 4'd8)
            drive_bit = !is_read && !tx_sh[7];
        else
            drive_bit = (cmd_q == cmd_read_byte_ack);   // master ack on reads
    end

    // sda only moves on quarters where scl stays put
    always_comb
    begin
        scl_nxt = in_high;
        sda_nxt = sda_oe;   // low_a holds sda while scl falls
        case (cmd_q)
            cmd_start:
            begin
                scl_nxt = 1'b1;
                sda_nxt = in_high;  // falls with scl high
            end
            cmd_restart:
                if (phase != phase_low_a)
                    sda_nxt = (phase == phase_high_b);
            cmd_stop:
                if (phase != phase_low_a)
                    sda_nxt = (phase != phase_high_b);  // rises with scl high
            default:
                if (phase != phase_low_a)
                    sda_nxt = drive_bit;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            cmd_q    <= cmd_idle;
            phase    <= phase_low_a;
            qcnt     <= '0;
            bit_cnt  <= '0;
            cmd_done <= 1'b0;
            ack_ok   <= 1'b0;
            scl      <= 1'b1;
            sda_oe   <= 1'b0;
        end
        else
        begin
            cmd_done <= 1'b0;
            if (ready)
            begin
                if (cmd_valid)
                begin
                    cmd_q   <= cmd;
                    phase   <= phase_low_a;
                    qcnt    <= '0;
                    bit_cnt <= '0;
                end
            end
            else
            begin
                scl    <= scl_nxt;
                sda_oe <= sda_nxt;
                qcnt   <= quarter_end ? '0 : qcnt + cnt_w'(1);
                if (quarter_end)
                    phase <= bit_phase_t'(phase + 2'd1);
                if (bit_end)
                    bit_cnt <= bit_cnt + 4'd1;
                // sampled late in the high phase, slave pulls low to ack
                if (bit_end && !is_read && is_byte && bit_cnt == 4'd8)
                    ack_ok <= !sda_in;
                if (cmd_end)
                begin
                    cmd_q    <= cmd_idle;
                    cmd_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (ready && cmd_valid)
            tx_sh <= tx_byte;
        else if (bit_end && is_byte)
            tx_sh <= {tx_sh[6:0], 1'b0};    // msb first
        if (bit_end && is_read && bit_cnt < 4'd8)
            rx_sh <= {rx_sh[6:0], sda_in};
    end

endmodule

/* verilog/eeprom_sequencer.sv */
`timescale 1ns/100ps

module eeprom_sequencer (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     wr,
    input  logic                     rd,
    input  eeprom_pkg::eeprom_addr_t addr,
    input  eeprom_pkg::eeprom_data_t wdata,
    output eeprom_pkg::eeprom_data_t rdata,
    output logic                     busy,
    output logic                     done,
    output logic                     nack_err,
    output i2c_pkg::i2c_cmd_t        cmd,
    output eeprom_pkg::eeprom_data_t tx_byte,
    output logic                     cmd_valid,
    input  logic                     ready,
    input  logic                     cmd_done,
    input  eeprom_pkg::eeprom_data_t rx_byte,
    input  logic                     ack_ok
);
    import i2c_pkg::*;
    import eeprom_pkg::*;

    localparam logic [3:0] st_idle    = 4'd0;
    localparam logic [3:0] st_start   = 4'd1;
    localparam logic [3:0] st_ctrl_w  = 4'd2;
    localparam logic [3:0] st_addr    = 4'd3;
    localparam logic [3:0] st_data    = 4'd4;
    localparam logic [3:0] st_restart = 4'd5;
    localparam logic [3:0] st_ctrl_r  = 4'd6;
    localparam logic [3:0] st_read    = 4'd7;
    localparam logic [3:0] st_stop    = 4'd8;

    logic [3:0]        state;
    logic [3:0]        state_after;
    logic              issued;      // command of this state handed over
    logic              accept;
    logic              rnw_q;
    eeprom_addr_t      addr_q;
    eeprom_data_t      wdata_q;
    logic              nack_seen;
    logic [PAGE_W-1:0] page;

    assign page      = addr_q[ADDR_W-1 -: PAGE_W];
    assign busy      = (state != st_idle);
    assign accept    = !busy && (wr || rd);
    assign cmd_valid = busy && ready && !issued;

    // command and byte for each state
    always_comb
    begin
        cmd     = cmd_write_byte;
        tx_byte = '0;
        case (state)
            st_start:   cmd = cmd_start;
            st_ctrl_w:  tx_byte = ctrl_byte(page, CTRL_WRITE);
            st_addr:    tx_byte = addr_q[ADDR_W-PAGE_W-1:0];
            st_data:    tx_byte = wdata_q;
            st_restart: cmd = cmd_restart;
            st_ctrl_r:  tx_byte = ctrl_byte(page, CTRL_READ);
            st_read:    cmd = cmd_read_byte_nack;   // single byte read
            st_stop:    cmd = cmd_stop;
            default:    cmd = cmd_idle;
        endcase
    end

    // where a state goes once its command finishes
    always_comb
    begin
        case (state)
            st_start:   state_after = st_ctrl_w;
            st_ctrl_w:  state_after = st_addr;
            st_addr:    state_after = rnw_q ? st_restart : st_data;
            st_restart: state_after = st_ctrl_r;
            st_ctrl_r:  state_after = st_read;
            st_stop:    state_after = st_idle;
            default:    state_after = st_stop;
        endcase
        if (cmd == cmd_write_byte && !ack_ok)
            state_after = st_stop;  // no ack, close the bus
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= st_idle;
            issued    <= 1'b0;
            done      <= 1'b0;
            nack_err  <= 1'b0;
            nack_seen <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (cmd_valid)
                issued <= 1'b1;
            if (accept)
            begin
                state     <= st_start;
                nack_seen <= 1'b0;
            end
            else if (cmd_done)
            begin
                issued <= 1'b0;
                state  <= state_after;
                if (cmd == cmd_write_byte && !ack_ok)
                    nack_seen <= 1'b1;
                if (state == st_stop)
                begin
                    done     <= 1'b1;
                    nack_err <= nack_seen;
                end
            end
        end
    end

    // request latch and read result
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            rnw_q   <= !wr;     // wr wins over rd
            addr_q  <= addr;
            wdata_q <= wdata;
        end
        if (cmd_done && state == st_stop && rnw_q && !nack_seen)
            rdata <= rx_byte;
    end

endmodule

/* verilog/eeprom_ctrl_top.sv */
`timescale 1ns/100ps

module eeprom_ctrl_top #(
    parameter int CLKS_PER_QUARTER = 2
) (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     wr,
    input  logic                     rd,
    input  eeprom_pkg::eeprom_addr_t addr,
    input  eeprom_pkg::eeprom_data_t wdata,
    output eeprom_pkg::eeprom_data_t rdata,
    output logic                     busy,
    output logic                     done,
    output logic                     nack_err,
    output logic                     scl,
    output logic                     sda_oe,
    input  logic                     sda_in
);
    import i2c_pkg::*;
    import eeprom_pkg::*;

    i2c_cmd_t     cmd;
    eeprom_data_t tx_byte;
    eeprom_data_t rx_byte;
    logic         cmd_valid;
    logic         ready;
    logic         cmd_done;
    logic         ack_ok;

    eeprom_sequencer u_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wdata     (wdata),
        .rdata     (rdata),
        .busy      (busy),
        .done      (done),
        .nack_err  (nack_err),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .cmd_valid (cmd_valid),
        .ready     (ready),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .ack_ok    (ack_ok)
    );

    // bus timing set here, one bit is four quarters
    i2c_byte_engine #(
        .CLKS_PER_QUARTER (CLKS_PER_QUARTER)
    ) u_engine (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .cmd_valid (cmd_valid),
        .ready     (ready),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .ack_ok    (ack_ok),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in)
    );

endmodule

/* verification/eeprom_slave_model.sv */
`timescale 1ns/100ps

module eeprom_slave_model (
    input  logic scl,
    input  logic sda,
    input  logic nack_addr,
    output logic sda_pull
);
    import eeprom_pkg::*;

    localparam int S_IDLE = 0;
    localparam int S_CTRL = 1;
    localparam int S_ADDR = 2;
    localparam int S_DATA = 3;
    localparam int S_READ = 4;

    logic [7:0] mem [0:2047];
    int         state = S_IDLE;
    int         next_state = S_IDLE;
    int         bit_cnt = 0;
    logic [7:0] shreg = 8'h00;
    logic [7:0] rbyte = 8'h00;
    logic [2:0] page = 3'd0;
    logic [7:0] word = 8'h00;
    logic       scl_q = 1'b1;
    logic       sda_q = 1'b1;
    logic       pull = 1'b0;

    assign sda_pull = pull;

    initial
    begin
        for (int a = 0; a < 2048; a++)
            mem[a] = a[7:0] ^ 8'ha5;
    end

    always @(scl or sda)
    begin
        if (scl && scl_q && sda_q && !sda)
        begin
            state   = S_CTRL;   // start or repeated start
            bit_cnt = 0;
            pull    = 1'b0;
        end
        else if (scl && scl_q && !sda_q && sda)
        begin
            state = S_IDLE;     // stop
            pull  = 1'b0;
        end
        else if (scl && !scl_q && state != S_IDLE)
        begin
            if (bit_cnt < 8 && state != S_READ)
                shreg = {shreg[6:0], sda};
            bit_cnt++;
        end
        else if (!scl && scl_q && state != S_IDLE)
        begin
            if (bit_cnt == 8 && state != S_READ)
            begin
                pull = 1'b1;
                case (state)
                    S_CTRL:
                    begin
                        if (shreg[7:4] == DEVICE_TYPE)
                        begin
                            page       = shreg[3:1];
                            next_state = shreg[0] ? S_READ : S_ADDR;
                        end
                        else
                        begin
                            pull       = 1'b0;
                            next_state = S_IDLE;
                        end
                    end
                    S_ADDR:
                    begin
                        word       = shreg;
                        pull       = !nack_addr;
                        next_state = nack_addr ? S_IDLE : S_DATA;
                    end
                    default:
                    begin
                        mem[{page, word}] = shreg;
                        next_state        = S_IDLE;
                    end
                endcase
            end
            else if (bit_cnt == 9)
            begin
                pull    = 1'b0;
                bit_cnt = 0;
                state   = (state == S_READ) ? S_IDLE : next_state;
                if (state == S_READ)
                begin
                    rbyte = mem[{page, word}];
                    pull  = !rbyte[7];
                end
            end
            else if (state == S_READ)
                pull = (bit_cnt < 8) ? !rbyte[7 - bit_cnt] : 1'b0;  // release for master ack
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* verification/tb_checker.sv */
`timescale 1ns/100ps

module tb_checker (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic                     done,
    input  logic                     busy,
    input  eeprom_pkg::eeprom_data_t rdata,
    input  logic                     nack_err,
    input  logic                     scl,
    input  logic                     sda_oe,
    input  int                       cur_test,
    input  logic                     cur_op,
    input  eeprom_pkg::eeprom_addr_t cur_addr,
    input  eeprom_pkg::eeprom_data_t cur_data,
    input  logic                     cur_nack,
    input  int                       n_expected,
    input  int                       timeouts,
    input  logic                     end_run,
    output logic                     summary_ready,
    output int                       fail_total
);
    import eeprom_pkg::*;

    eeprom_data_t shadow [0:2047];
    int   tests_run = 0;
    int   tests_failed = 0;
    int   done_count = 0;
    int   errors = 0;
    logic reset_seen = 1'b0;

    initial
    begin
        summary_ready = 1'b0;
        fail_total    = 0;
        for (int a = 0; a < 2048; a++)
            shadow[a] = a[7:0] ^ 8'ha5;
    end

    task automatic compare(input string name, input int got, input int exp, inout logic bad);
        if (got != exp)
        begin
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
            bad = 1'b1;
        end
    endtask

    task automatic close_test(input int num, input string what, input logic bad);
        tests_run++;
        if (bad)
        begin
            tests_failed++;
            errors++;
        end
        $display("test %0d %s: %s", num, what, bad ? "FAIL" : "ok");
    endtask

    always @(posedge CLK)
    begin
        logic bad;
        bad = 1'b0;
        if (RESET)
            reset_seen <= 1'b1;
        else if (reset_seen)
        begin
            reset_seen <= 1'b0;
            compare("scl", int'(scl), 1, bad);
            compare("sda_oe", int'(sda_oe), 0, bad);
            compare("busy", int'(busy), 0, bad);
            compare("done", int'(done), 0, bad);
            compare("nack_err", int'(nack_err), 0, bad);
            close_test(0, "reset state", bad);
        end
        else if (done)
        begin
            done_count++;
            if (cur_op)
            begin
                compare("nack_err", int'(nack_err), 0, bad);
                compare("rdata", int'(rdata), int'(shadow[cur_addr]), bad);
                close_test(cur_test, $sformatf("read  %h", cur_addr), bad);
            end
            else
            begin
                compare("nack_err", int'(nack_err), int'(cur_nack), bad);
                if (!cur_nack)
                    shadow[cur_addr] = cur_data;
                close_test(cur_test, $sformatf("write %h", cur_addr), bad);
            end
        end
    end

    always @(posedge end_run)
    begin
        if (done_count != n_expected)
        begin
            $display("Error at %0t: done_count got %0d expected %0d", $time, done_count,
                     n_expected);
            errors++;
        end
        fail_total = errors + timeouts;
        $display("tests %0d, failed %0d, timeouts %0d, done pulses %0d", tests_run,
                 tests_failed, timeouts, done_count);
        summary_ready = 1'b1;
    end

endmodule

/* verification/tb_eeprom_ctrl.sv */
`timescale 1ns/100ps

module tb_eeprom_ctrl;
    import eeprom_pkg::*;

    localparam int N_ENTRIES   = 13;
    localparam int DONE_WAIT   = 2000;  // clk cycles per transaction, generous
    localparam int REPORT_WAIT = 10;
    localparam logic OP_WR = 1'b0;
    localparam logic OP_RD = 1'b1;

    logic         CLK;
    logic         RESET;
    logic         wr;
    logic         rd;
    eeprom_addr_t addr;
    eeprom_data_t wdata;
    eeprom_data_t rdata;
    logic         busy;
    logic         done;
    logic         nack_err;
    logic         scl;
    logic         sda_oe;
    logic         sda;
    logic         slave_pull;
    logic         nack_flag;

    // stimulus table
    logic         tbl_op    [N_ENTRIES];
    eeprom_addr_t tbl_addr  [N_ENTRIES];
    eeprom_data_t tbl_data  [N_ENTRIES];
    logic         tbl_nack  [N_ENTRIES];
    logic         tbl_extra [N_ENTRIES];   // second strobe while busy

    int           cur_test;
    logic         cur_op;
    eeprom_addr_t cur_addr;
    eeprom_data_t cur_data;
    logic         cur_nack;
    int           timeouts;
    logic         end_run;
    logic         summary_ready;
    int           fail_total;
    int           seed;

    // open drain bus with pull-up
    assign sda = !(sda_oe || slave_pull);

    eeprom_ctrl_top #(.CLKS_PER_QUARTER(2)) DUT (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
        .rdata(rdata), .busy(busy), .done(done), .nack_err(nack_err),
        .scl(scl), .sda_oe(sda_oe), .sda_in(sda)
    );

    eeprom_slave_model u_slave (
        .scl(scl), .sda(sda), .nack_addr(nack_flag), .sda_pull(slave_pull)
    );

    tb_checker u_chk (
        .CLK(CLK), .RESET(RESET), .done(done), .busy(busy), .rdata(rdata),
        .nack_err(nack_err), .scl(scl), .sda_oe(sda_oe),
        .cur_test(cur_test), .cur_op(cur_op), .cur_addr(cur_addr), .cur_data(cur_data),
        .cur_nack(cur_nack), .n_expected(N_ENTRIES), .timeouts(timeouts),
        .end_run(end_run), .summary_ready(summary_ready), .fail_total(fail_total)
    );

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = !CLK;
    end

    task automatic set_entry(input int i, input logic op, input eeprom_addr_t a,
                             input eeprom_data_t d, input logic nk, input logic ex);
        tbl_op[i]    = op;
        tbl_addr[i]  = a;
        tbl_data[i]  = d;
        tbl_nack[i]  = nk;
        tbl_extra[i] = ex;
    endtask

    task automatic run_entry(input int i);
        int   cycles;
        logic got;
        logic extra_sent;
        cycles     = 0;
        got        = 1'b0;
        extra_sent = 1'b0;
        cur_test   = i + 1;
        cur_op     = tbl_op[i];
        cur_addr   = tbl_addr[i];
        cur_data   = tbl_data[i];
        cur_nack   = tbl_nack[i];
        nack_flag  = tbl_nack[i];
        addr       = tbl_addr[i];
        wdata      = tbl_data[i];
        wr         = (tbl_op[i] == OP_WR);
        rd         = (tbl_op[i] == OP_RD);
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
        while (!got && cycles < DONE_WAIT)
        begin
            if (done)
                got = 1'b1;
            else
            begin
                rd = 1'b0;
                if (tbl_extra[i] && busy && !extra_sent && cycles > 20)
                begin
                    rd         = 1'b1;  // must be dropped
                    addr       = ~tbl_addr[i];
                    extra_sent = 1'b1;
                end
                @(negedge CLK);
                cycles++;
            end
        end
        rd = 1'b0;
        @(negedge CLK);     // hold entry info until the checker has seen done
        if (!got)
        begin
            timeouts++;
            $display("Timeout: no done seen for test %0d", i + 1);
        end
    endtask

    initial
    begin
        int cycles;
        seed      = 32'h0aec_3b89;
        RESET     = 1'b1;
        wr        = 1'b0;
        rd        = 1'b0;
        addr      = '0;
        wdata     = '0;
        nack_flag = 1'b0;
        cur_test  = 0;
        cur_op    = OP_RD;
        cur_addr  = '0;
        cur_data  = '0;
        cur_nack  = 1'b0;
        timeouts  = 0;
        end_run   = 1'b0;
        cycles    = 0;

        set_entry(0,  OP_WR, 11'h123, eeprom_data_t'($random(seed)), 1'b0, 1'b0);
        set_entry(1,  OP_RD, 11'h123, 8'h00, 1'b0, 1'b0);
        set_entry(2,  OP_RD, 11'h045, 8'h00, 1'b0, 1'b0);   // never written
        set_entry(3,  OP_WR, 11'h1ab, eeprom_data_t'($random(seed)), 1'b0, 1'b0);
        set_entry(4,  OP_WR, 11'h5ab, ~tbl_data[3], 1'b0, 1'b0);   // differs from page 1
        set_entry(5,  OP_RD, 11'h1ab, 8'h00, 1'b0, 1'b0);
        set_entry(6,  OP_RD, 11'h5ab, 8'h00, 1'b0, 1'b0);
        set_entry(7,  OP_WR, 11'h2c0, 8'h3c, 1'b1, 1'b0);   // slave nacks word address
        set_entry(8,  OP_RD, 11'h2c0, 8'h00, 1'b0, 1'b0);
        set_entry(9,  OP_WR, 11'h333, eeprom_data_t'($random(seed)), 1'b0, 1'b1);
        set_entry(10, OP_RD, 11'h333, 8'h00, 1'b0, 1'b0);
        set_entry(11, OP_WR, 11'h7ff, eeprom_data_t'($random(seed)), 1'b0, 1'b0);
        set_entry(12, OP_RD, 11'h7ff, 8'h00, 1'b0, 1'b0);

        repeat (5) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        for (int i = 0; i < N_ENTRIES; i++)
            run_entry(i);

        end_run = 1'b1;
        while (!summary_ready && cycles < REPORT_WAIT)
        begin
            @(negedge CLK);
            cycles++;
        end
        if (summary_ready && fail_total == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* all.f */
verilog/i2c_pkg.sv
verilog/eeprom_pkg.sv
verilog/i2c_byte_engine.sv
verilog/eeprom_sequencer.sv
verilog/eeprom_ctrl_top.sv
verification/eeprom_slave_model.sv
verification/tb_checker.sv
verification/tb_eeprom_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# build and run the EEPROM controller testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f all.f --top-module tb_eeprom_ctrl -o sim_eeprom
./obj_dir/sim_eeprom > sim.log 2>&1 || true
cat sim.log

grep -q "All checks passed" sim.log
echo "simulation passed"
